//--- hw/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// 640x480 at 60 Hz with a 25.175 MHz pixel clock

// horizontal timing in pixel clocks
`define H_ACTIVE 640 // visible columns
`define H_SYNC_START 656 // front porch of 16 ends here
`define H_SYNC_END 752 // 96 clocks of sync pulse
`define H_TOTAL 800 // back porch of 48 fills the rest

// vertical timing in lines
`define V_ACTIVE 480 // visible lines
`define V_SYNC_START 490 // front porch of 10 lines
`define V_SYNC_END 492 // two lines of sync pulse
`define V_TOTAL 525 // back porch of 33 lines

// test pattern geometry
// eight bars across the visible width
`define BAR_WIDTH 80

`endif

//--- hw/video_pkg.sv
package video_pkg;

	// raster positions
	typedef logic [9:0] pixel_count_t; // column within a line, up to 799
	typedef logic [9:0] line_count_t; // line within a frame, up to 524

	// line buffer address is the bank bit then the column
	typedef logic [10:0] line_addr_t;

	// one bit per channel at the pins
	// red in bit 2, green in bit 1, blue in bit 0
	typedef logic [2:0] rgb_t;

	// rainbow channel intensity, only the top bit reaches the pins
	typedef logic [7:0] color_level_t;

	// motion of one rainbow channel
	typedef enum logic [1:0] {
		hue_hold = 2'b00, // parked at 0 or 255
		hue_rise = 2'b01, // counting up one per frame
		hue_fall = 2'b10 // counting down one per frame
	} hue_dir_e;

endpackage

//--- hw/line_write_if.sv
`timescale 1ns/1ns

// one line buffer write per clock, no back-pressure
interface line_write_if;

	logic write_enable; // high for each active column being drawn
	video_pkg::line_addr_t write_addr; // bank bit and column
	video_pkg::rgb_t write_data; // pixel color
	logic write_bank; // bank being filled

	// pattern side
	modport source (
		output write_enable,
		output write_addr,
		output write_data,
		output write_bank
	);

	// memory side
	modport buffer (
		input write_enable,
		input write_addr,
		input write_data,
		input write_bank
	);

endinterface

//--- hw/raster_timing.sv
`timescale 1ns/1ns
`include "video_config.svh"

module raster_timing (
	input logic pixel_clock,
	input logic reset,
	output video_pkg::pixel_count_t pixel_x, // display column
	output video_pkg::pixel_count_t draw_x, // drawing column
	output video_pkg::line_count_t line_y, // display line
	output video_pkg::line_count_t draw_line, // drawing line, one ahead
	output logic frame_strobe,
	output logic hsync_raw,
	output logic vsync_raw,
	output logic blank_raw
);

	localparam video_pkg::pixel_count_t last_pixel =
		video_pkg::pixel_count_t'(`H_TOTAL - 1);
	localparam video_pkg::line_count_t last_line =
		video_pkg::line_count_t'(`V_TOTAL - 1);

	logic line_end; // last clock of every line

	assign line_end = (pixel_x == last_pixel);

	// horizontal counter, free running
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			pixel_x <= '0;
		end else if (line_end) begin
			pixel_x <= '0;
		end else begin
			pixel_x <= pixel_x + 1'b1;
		end
	end

	// display line and drawing line step together at end of line
	// reset puts display on the last line so line 0 is drawn first
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			line_y <= last_line;
			draw_line <= '0; // one ahead of last_line, already wrapped
		end else if (line_end) begin
			if (line_y == last_line) begin
				line_y <= '0;
			end else begin
				line_y <= line_y + 1'b1;
			end
			// wraps one line earlier than line_y
			if (draw_line == last_line) begin
				draw_line <= '0;
			end else begin
				draw_line <= draw_line + 1'b1;
			end
		end
	end

	// drawing runs column for column with display
	assign draw_x = pixel_x;

	// first clock after the last visible line, hue walker steps here
	assign frame_strobe = (pixel_x == '0) && (line_y == `V_ACTIVE);

	// sync pulses are active low
	assign hsync_raw = !((pixel_x >= `H_SYNC_START) && (pixel_x < `H_SYNC_END));
	assign vsync_raw = !((line_y >= `V_SYNC_START) && (line_y < `V_SYNC_END));

	// high anywhere outside the 640x480 window
	assign blank_raw = (pixel_x >= `H_ACTIVE) || (line_y >= `V_ACTIVE);

endmodule

//--- hw/color_bar_source.sv
`timescale 1ns/1ns
`include "video_config.svh"

module color_bar_source (
	input logic pixel_clock,
	input logic reset,
	input video_pkg::pixel_count_t draw_x,
	input video_pkg::line_count_t draw_line,
	input logic frame_strobe, // one pulse per frame
	line_write_if.source line_write
);

	localparam int channels = 3; // red, green, blue in walk order

	// rainbow bar state, index 0 red, 1 green, 2 blue
	video_pkg::color_level_t level [channels];
	video_pkg::hue_dir_e dir [channels];

	// bar selection for the current draw column
	logic [2:0] bar_index; // 0..7 across the visible width
	logic [6:0] bar_col; // column inside the bar, 0..79
	logic separator; // black gap between bars
	logic draw_active; // inside the visible window
	video_pkg::rgb_t bar_color;
	video_pkg::rgb_t rainbow_color;

	// hue walker
	// one channel moves at a time and passes the motion on at its limit
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			// start at pure red with green on its way up
			level[0] <= 8'hff;
			level[1] <= 8'h00;
			level[2] <= 8'h00;
			dir[0] <= video_pkg::hue_hold;
			dir[1] <= video_pkg::hue_rise;
			dir[2] <= video_pkg::hue_hold;
		end else if (frame_strobe) begin
			for (int ch = 0; ch < channels; ch++) begin
				case (dir[ch])
					video_pkg::hue_rise: begin
						if (level[ch] == 8'hff) begin
							dir[ch] <= video_pkg::hue_hold; // park at full
							// channel before this one starts fading
							dir[(ch + 2) % channels] <= video_pkg::hue_fall;
						end else begin
							level[ch] <= level[ch] + 8'h01;
						end
					end
					video_pkg::hue_fall: begin
						if (level[ch] == 8'h00) begin
							dir[ch] <= video_pkg::hue_hold; // park at zero
							// two on in walk order, i.e. the one before
							dir[(ch + 2) % channels] <= video_pkg::hue_rise;
						end else begin
							level[ch] <= level[ch] - 8'h01;
						end
					end
					default: begin
						// holding channels wait for a neighbour
					end
				endcase
			end
		end
	end

	// only the top bit of each level reaches the one bit pins
	assign rainbow_color = {level[0][7], level[1][7], level[2][7]};

	// column decode
	assign bar_index = 3'(draw_x / `BAR_WIDTH);
	assign bar_col = 7'(draw_x % `BAR_WIDTH);
	// last column of each bar and first column of every bar but the first
	assign separator = (bar_col == 7'(`BAR_WIDTH - 1)) ||
		((bar_col == 7'd0) && (draw_x != '0));
	assign draw_active = (draw_x < `H_ACTIVE) && (draw_line < `V_ACTIVE);

	always_comb begin
		case (bar_index)
			3'd0: bar_color = 3'b100; // red
			3'd1: bar_color = 3'b110; // yellow
			3'd2: bar_color = 3'b010; // green
			3'd3: bar_color = 3'b011; // cyan
			3'd4: bar_color = 3'b001; // blue
			3'd5: bar_color = 3'b101; // magenta
			3'd6: bar_color = 3'b111; // white
			default: bar_color = rainbow_color; // walking hue
		endcase
		if (separator) begin
			bar_color = 3'b000;
		end
	end

	// write strobe, one clock after the draw position
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			line_write.write_enable <= 1'b0;
		end else begin
			line_write.write_enable <= draw_active;
		end
	end

	// write payload, follows the strobe
	always_ff @(posedge pixel_clock) begin
		line_write.write_bank <= draw_line[0]; // opposite of the read bank
		line_write.write_addr <= {draw_line[0], draw_x};
		line_write.write_data <= bar_color;
	end

endmodule

//--- hw/line_buffer.sv
`timescale 1ns/1ns

module line_buffer (
	input logic pixel_clock,
	input video_pkg::line_addr_t read_addr, // read bank and column
	line_write_if.buffer line_write,
	output video_pkg::rgb_t read_data
);

	localparam int addr_bits = $bits(video_pkg::line_addr_t);
	localparam int depth = 1 << addr_bits; // two banks of 1024
	localparam int col_bits = addr_bits - 1;

	// ping-pong storage, bank in the top address bit
	video_pkg::rgb_t mem [depth];

	video_pkg::line_addr_t write_index;

	// bank comes from write_bank, column from the low address bits
	assign write_index = {line_write.write_bank, line_write.write_addr[col_bits-1:0]};

	// write port, one pixel per clock when enabled
	always_ff @(posedge pixel_clock) begin
		if (line_write.write_enable) begin
			mem[write_index] <= line_write.write_data;
		end
	end

	// registered read, data one clock after the address
	always_ff @(posedge pixel_clock) begin
		read_data <= mem[read_addr];
	end

endmodule

//--- hw/video_top.sv
`timescale 1ns/1ns

module video_top (
	input logic pixel_clock,
	input logic reset,
	output logic red,
	output logic green,
	output logic blue,
	output logic hsync,
	output logic vsync,
	output logic blank
);

	video_pkg::pixel_count_t pixel_x;
	video_pkg::pixel_count_t draw_x;
	video_pkg::line_count_t line_y;
	video_pkg::line_count_t draw_line;
	logic frame_strobe;
	logic hsync_raw;
	logic vsync_raw;
	logic blank_raw;
	video_pkg::line_addr_t read_addr;
	video_pkg::rgb_t read_data;

	// two stage delay lines, stage 1 lines up with read_data
	logic [1:0] hsync_delay;
	logic [1:0] vsync_delay;
	logic [1:0] blank_delay;

	line_write_if line_write ();

	raster_timing u_timing (
		.pixel_clock(pixel_clock),
		.reset(reset),
		.pixel_x(pixel_x),
		.draw_x(draw_x),
		.line_y(line_y),
		.draw_line(draw_line),
		.frame_strobe(frame_strobe),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.blank_raw(blank_raw)
	);

	color_bar_source u_bars (
		.pixel_clock(pixel_clock),
		.reset(reset),
		.draw_x(draw_x),
		.draw_line(draw_line),
		.frame_strobe(frame_strobe),
		.line_write(line_write.source)
	);

	// read bank follows the display line
	assign read_addr = {line_y[0], pixel_x};

	line_buffer u_buffer (
		.pixel_clock(pixel_clock),
		.read_addr(read_addr),
		.line_write(line_write.buffer),
		.read_data(read_data)
	);

	// pins reflect position P two clocks after the counters sit at P
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			hsync_delay <= 2'b00; // all pins low while in reset
			vsync_delay <= 2'b00;
			blank_delay <= 2'b00;
			{red, green, blue} <= 3'b000;
		end else begin
			hsync_delay <= {hsync_delay[0], hsync_raw};
			vsync_delay <= {vsync_delay[0], vsync_raw};
			blank_delay <= {blank_delay[0], blank_raw};
			// black outside the visible window
			{red, green, blue} <= blank_delay[0] ? 3'b000 : read_data;
		end
	end

	assign hsync = hsync_delay[1];
	assign vsync = vsync_delay[1];
	assign blank = blank_delay[1];

endmodule

//--- verification/video_properties.sv
`timescale 1ns/1ns
`include "video_config.svh"

module video_properties (
	input logic pixel_clock,
	input logic reset,
	input logic red,
	input logic green,
	input logic blue,
	input logic hsync,
	input logic vsync,
	input logic blank
);

	localparam int rainbow_first = `H_ACTIVE - `BAR_WIDTH + 1; // left edge after the gap

	int failures = 0; // bumped by every failing assertion, read by video_tb

	logic hsync_seen_high; // pins out of reset
	logic tracking; // shadow position locked to the pins
	video_pkg::pixel_count_t sx; // column shown on the pins
	video_pkg::line_count_t sy; // line shown on the pins
	video_pkg::rgb_t pixel;
	video_pkg::rgb_t frame_color; // rainbow color of the frame on screen
	logic have_frame; // frame_color holds a real frame

	int col_in_bar;
	int bar_number;
	logic exp_hsync;
	logic exp_vsync;
	logic exp_blank;
	logic separator;
	logic in_rainbow;
	logic first_rainbow;
	video_pkg::rgb_t exp_bar;
	video_pkg::rgb_t exp_next;

	assign pixel = {red, green, blue};

	// first hsync fall marks column H_SYNC_START of the last line
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			hsync_seen_high <= 1'b0;
			tracking <= 1'b0;
			sx <= '0;
			sy <= '0;
		end else if (!tracking) begin
			if (hsync) begin
				hsync_seen_high <= 1'b1;
			end else if (hsync_seen_high) begin
				tracking <= 1'b1;
				sx <= video_pkg::pixel_count_t'(`H_SYNC_START + 1); // next clock
				sy <= video_pkg::line_count_t'(`V_TOTAL - 1);
			end
		end else if (sx == video_pkg::pixel_count_t'(`H_TOTAL - 1)) begin
			sx <= '0;
			if (sy == video_pkg::line_count_t'(`V_TOTAL - 1)) begin
				sy <= '0;
			end else begin
				sy <= sy + 1'b1;
			end
		end else begin
			sx <= sx + 1'b1;
		end
	end

	assign exp_hsync = !((sx >= `H_SYNC_START) && (sx < `H_SYNC_END)); // active low
	assign exp_vsync = !((sy >= `V_SYNC_START) && (sy < `V_SYNC_END));
	assign exp_blank = (sx >= `H_ACTIVE) || (sy >= `V_ACTIVE);

	assign col_in_bar = int'(sx) % `BAR_WIDTH;
	assign bar_number = int'(sx) / `BAR_WIDTH;
	assign separator = (col_in_bar == `BAR_WIDTH - 1) || ((col_in_bar == 0) && (sx != '0));
	assign in_rainbow = (bar_number == 7) && !separator;
	assign first_rainbow = (sx == video_pkg::pixel_count_t'(rainbow_first)) && (sy == '0);

	// fixed bars left to right
	always_comb begin
		case (bar_number)
			0: exp_bar = 3'b100;
			1: exp_bar = 3'b110;
			2: exp_bar = 3'b010;
			3: exp_bar = 3'b011;
			4: exp_bar = 3'b001;
			5: exp_bar = 3'b101;
			default: exp_bar = 3'b111; // bar 6 is white
		endcase
	end

	// one step around the hue circle
	always_comb begin
		case (frame_color)
			3'b100: exp_next = 3'b110;
			3'b110: exp_next = 3'b010;
			3'b010: exp_next = 3'b011;
			3'b011: exp_next = 3'b001;
			3'b001: exp_next = 3'b101;
			3'b101: exp_next = 3'b100;
			default: exp_next = 3'b000; // not a hue
		endcase
	end

	// rainbow color latched at the first lit rainbow pixel of each frame
	always_ff @(posedge pixel_clock) begin
		if (reset) begin
			frame_color <= '0;
			have_frame <= 1'b0;
		end else if (tracking && first_rainbow) begin
			frame_color <= pixel;
			have_frame <= 1'b1;
		end
	end

	// shadow counters must be locked before the first vsync pulse
	hsync_locked: assert property (@(posedge pixel_clock) disable iff (reset)
		$fell(vsync) |-> tracking)
	else begin
		$error("hsync never fell before vsync went low at %0t", $time);
		failures++;
	end

	hsync_window: assert property (@(posedge pixel_clock) disable iff (reset)
		tracking |-> (hsync == exp_hsync))
	else begin
		$error("Fail %0t: hsync %b at column %0d", $time, hsync, sx);
		failures++;
	end

	vsync_window: assert property (@(posedge pixel_clock) disable iff (reset)
		tracking |-> (vsync == exp_vsync))
	else begin
		$error("Fail %0t: vsync %b on line %0d", $time, vsync, sy);
		failures++;
	end

	blank_window: assert property (@(posedge pixel_clock) disable iff (reset)
		tracking |-> (blank == exp_blank))
	else begin
		$error("Fail %0t: blank %b at %0d,%0d", $time, blank, sx, sy);
		failures++;
	end

	blank_is_black: assert property (@(posedge pixel_clock) disable iff (reset)
		blank |-> (pixel == 3'b000))
	else begin
		$error("Fail %0t: color %b during blanking", $time, pixel);
		failures++;
	end

	gap_is_black: assert property (@(posedge pixel_clock) disable iff (reset)
		(tracking && !exp_blank && separator) |-> (pixel == 3'b000))
	else begin
		$error("Fail %0t: separator at %0d,%0d is %b", $time, sx, sy, pixel);
		failures++;
	end

	fixed_bar_color: assert property (@(posedge pixel_clock) disable iff (reset)
		(tracking && !exp_blank && !separator && (bar_number < 7)) |-> (pixel == exp_bar))
	else begin
		$error("Fail %0t: bar %0d at %0d,%0d is %b", $time, bar_number, sx, sy, pixel);
		failures++;
	end

	rainbow_steady: assert property (@(posedge pixel_clock) disable iff (reset)
		(tracking && !exp_blank && in_rainbow && !first_rainbow) |-> (pixel == frame_color))
	else begin
		$error("Fail %0t: rainbow at %0d,%0d is %b, frame has %b",
			$time, sx, sy, pixel, frame_color);
		failures++;
	end

	rainbow_walk: assert property (@(posedge pixel_clock) disable iff (reset)
		(tracking && first_rainbow) |->
			(have_frame ? ((pixel == frame_color) || (pixel == exp_next)) : (pixel == 3'b100)))
	else begin
		$error("Fail %0t: rainbow moved from %b to %b", $time, frame_color, pixel);
		failures++;
	end

endmodule

bind video_top video_properties props (
	.pixel_clock(pixel_clock),
	.reset(reset),
	.red(red),
	.green(green),
	.blue(blue),
	.hsync(hsync),
	.vsync(vsync),
	.blank(blank)
);

//--- verification/video_tb.sv
`timescale 1ns/1ns
`include "video_config.svh"

module video_tb;

	localparam int frame_clocks = `H_TOTAL * `V_TOTAL; // 420000 clocks per frame
	localparam int wait_limit = 2 * frame_clocks; // a full frame plus margin
	localparam int frames_to_run = 3;

	logic pixel_clock;
	logic reset;
	logic red;
	logic green;
	logic blue;
	logic hsync;
	logic vsync;
	logic blank;

	int timeout_count;
	int assertion_count;

	video_top DUT (
		.pixel_clock(pixel_clock),
		.reset(reset),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank)
	);

	// 100 ns period
	initial begin
		pixel_clock = 1'b0;
		forever begin
			#50 pixel_clock = ~pixel_clock;
		end
	end

	// vsync is sampled on the falling edge, away from the DUT updates
	task automatic wait_for_vsync(input logic level, input string what);
		int cycles;
		cycles = 0;
		while ((vsync !== level) && (cycles < wait_limit)) begin
			@(negedge pixel_clock);
			cycles++;
		end
		if (vsync !== level) begin
			$display("Timed out at %0t after %0d clocks waiting for vsync %s",
				$time, cycles, what);
			timeout_count++;
		end
	endtask

	initial begin
		reset = 1'b1;
		timeout_count = 0;
		assertion_count = 0;
		repeat (3) begin
			@(posedge pixel_clock);
		end
		reset <= 1'b0;

		// vsync sits low in reset, so the first rise is not a frame
		wait_for_vsync(1'b1, "to come up after reset");
		for (int frame = 0; frame < frames_to_run; frame++) begin
			wait_for_vsync(1'b0, "to fall");
			wait_for_vsync(1'b1, "to rise");
		end

		// checker has seen every edge up to here
		@(negedge pixel_clock);
		assertion_count = DUT.props.failures;
		$display("Run over at %0t: %0d timeouts, %0d assertion failures",
			$time, timeout_count, assertion_count);
		if ((timeout_count == 0) && (assertion_count == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+hw
hw/video_pkg.sv
hw/line_write_if.sv
hw/raster_timing.sv
hw/color_bar_source.sv
hw/line_buffer.sv
hw/video_top.sv
verification/video_properties.sv
verification/video_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module video_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# keep running past assertion errors so the closing line is printed
output=$(./obj_dir/Vvideo_tb +verilator+error+limit+100000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
